/* verilog/ddr_pkg.sv */
/* ddr game constants
   grid size, scoring weights and beat timing shared by every block */
`default_nettype none

package ddr_pkg;

	// note grid, row 7 on top
	localparam int NUM_LANES = 4;
	localparam int NUM_ROWS = 8;
	localparam int ROW_BITS = $clog2(NUM_ROWS);
	localparam int HIT_ROW = 1;
	localparam int NEAR_ROW = 2;

	// beat timing and note generator
	localparam int BEAT_CYCLES = 16;
	localparam int BEAT_BITS = $clog2(BEAT_CYCLES);
	localparam int LFSR_WIDTH = 9;
	localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 9'd1;

	// score display
	localparam int NUM_DIGITS = 6;

	// per-press points, delta is the sum over all lanes
	localparam int DELTA_WIDTH = 5;
	localparam logic signed [DELTA_WIDTH-1:0] PTS_HIT = 5'sd2;
	localparam logic signed [DELTA_WIDTH-1:0] PTS_NEAR = 5'sd1;
	localparam logic signed [DELTA_WIDTH-1:0] PTS_MISS = 5'sd2;

endpackage

`default_nettype wire

/* verilog/game_if.sv */
/* game bus between the input, processing and output sides
   carries beat, spawn, press, note field and score digits */
`timescale 1ns/1ns
`default_nettype none

interface game_if;

	logic beat;
	logic [ddr_pkg::NUM_LANES-1:0] spawn;
	logic [ddr_pkg::NUM_LANES-1:0] press;
	logic [ddr_pkg::NUM_ROWS-1:0][ddr_pkg::NUM_LANES-1:0] field;
	logic [ddr_pkg::NUM_DIGITS-1:0][3:0] digits;

	modport input_side (output beat, output spawn, output press);

	modport process_side (input beat, input spawn, input press, output field, output digits);

	modport output_side (input field, input digits);

endinterface

`default_nettype wire

/* verilog/key_sampler.sv */
/* key sampler
   two-flop synchronizer plus rising-edge detect, one press per key push */
`timescale 1ns/1ns
`default_nettype none

module key_sampler (
	input wire logic clk,
	input wire logic reset,
	input wire logic [ddr_pkg::NUM_LANES-1:0] key,
	game_if.input_side bus
);

	logic [ddr_pkg::NUM_LANES-1:0] sync_a;
	logic [ddr_pkg::NUM_LANES-1:0] sync_b;
	logic [ddr_pkg::NUM_LANES-1:0] key_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_a <= '0;
			sync_b <= '0;
			key_last <= '0;
			bus.press <= '0;
		end else begin
			sync_a <= key;
			sync_b <= sync_a;
			key_last <= sync_b;
			// high only on the first sample after a low one
			bus.press <= sync_b & ~key_last;
		end
	end

endmodule

`default_nettype wire

/* verilog/note_source.sv */
/* note source
   beat timer and 9-bit LFSR that picks the lanes of each new note row */
`timescale 1ns/1ns
`default_nettype none

module note_source (
	input wire logic clk,
	input wire logic reset,
	game_if.input_side bus
);

	logic [ddr_pkg::BEAT_BITS-1:0] beat_count;
	logic [ddr_pkg::LFSR_WIDTH-1:0] lfsr;
	logic feedback;

	// taps 9 and 5, shifted in at the bottom
	assign feedback = lfsr[ddr_pkg::LFSR_WIDTH-1] ^ lfsr[4];

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_count <= '0;
			bus.beat <= 1'b0;
			lfsr <= ddr_pkg::LFSR_SEED;
		end else begin
			if (beat_count == ddr_pkg::BEAT_BITS'(ddr_pkg::BEAT_CYCLES - 1)) begin
				beat_count <= '0;
				bus.beat <= 1'b1;
				// step together with the beat so spawn is fresh
				lfsr <= {lfsr[ddr_pkg::LFSR_WIDTH-2:0], feedback};
			end else begin
				beat_count <= beat_count + 1'b1;
				bus.beat <= 1'b0;
			end
		end
	end

	// new top row straight from the low lfsr bits
	assign bus.spawn = lfsr[ddr_pkg::NUM_LANES-1:0];

endmodule

`default_nettype wire

/* verilog/note_lanes.sv */
/* note lanes
   judges presses against the hit zone, then shifts the field on each beat */
`timescale 1ns/1ns
`default_nettype none

module note_lanes (
	input wire logic clk,
	input wire logic reset,
	game_if.process_side bus,
	output logic signed [ddr_pkg::DELTA_WIDTH-1:0] delta,
	output logic delta_valid
);

	logic [ddr_pkg::NUM_ROWS-1:0][ddr_pkg::NUM_LANES-1:0] judged;
	logic [ddr_pkg::NUM_ROWS-1:0][ddr_pkg::NUM_LANES-1:0] next_field;
	logic signed [ddr_pkg::DELTA_WIDTH-1:0] lane_sum;

	// judge first, against the field as it stands now
	always_comb begin
		judged = bus.field;
		lane_sum = '0;
		for (int l = 0; l < ddr_pkg::NUM_LANES; l++) begin
			if (bus.press[l]) begin
				if (judged[ddr_pkg::HIT_ROW][l]) begin
					lane_sum = lane_sum + ddr_pkg::PTS_HIT;
					judged[ddr_pkg::HIT_ROW][l] = 1'b0;
				end else if (judged[ddr_pkg::NEAR_ROW][l]) begin
					lane_sum = lane_sum + ddr_pkg::PTS_NEAR;
					judged[ddr_pkg::NEAR_ROW][l] = 1'b0;
				end else begin
					// empty lane costs points
					lane_sum = lane_sum - ddr_pkg::PTS_MISS;
				end
			end
		end
	end

	// then the beat moves everything down one row
	always_comb begin
		next_field = judged;
		if (bus.beat) begin
			for (int r = 0; r < ddr_pkg::NUM_ROWS - 1; r++) begin
				next_field[r] = judged[r+1];
			end
			next_field[ddr_pkg::NUM_ROWS-1] = bus.spawn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.field <= '0;
			delta_valid <= 1'b0;
		end else begin
			bus.field <= next_field;
			delta_valid <= |bus.press;
		end
	end

	// payload, only looked at with delta_valid
	always_ff @(posedge clk) begin
		delta <= lane_sum;
	end

endmodule

`default_nettype wire

/* verilog/score_keeper.sv */
/* score keeper
   six-digit BCD score, signed delta with decimal carry and borrow, clamped */
`timescale 1ns/1ns
`default_nettype none

module score_keeper (
	input wire logic clk,
	input wire logic reset,
	input wire logic signed [ddr_pkg::DELTA_WIDTH-1:0] delta,
	input wire logic delta_valid,
	game_if.process_side bus
);

	logic [ddr_pkg::DELTA_WIDTH-1:0] abs_delta;
	logic [3:0] magnitude;
	logic [ddr_pkg::NUM_DIGITS-1:0][3:0] sum_digits;
	logic [ddr_pkg::NUM_DIGITS-1:0][3:0] diff_digits;
	logic carry;
	logic borrow;
	logic [4:0] add_acc;
	logic [4:0] sub_acc;
	logic [3:0] operand;

	// delta never exceeds one digit in size
	assign abs_delta = delta[ddr_pkg::DELTA_WIDTH-1] ? -delta : delta;
	assign magnitude = abs_delta[3:0];

	always_comb begin
		carry = 1'b0;
		borrow = 1'b0;
		add_acc = '0;
		sub_acc = '0;
		for (int i = 0; i < ddr_pkg::NUM_DIGITS; i++) begin
			operand = (i == 0) ? magnitude : 4'd0;
			// decimal add, carry into the next digit past 9
			add_acc = {1'b0, bus.digits[i]} + {1'b0, operand} + {4'd0, carry};
			if (add_acc > 5'd9) begin
				sum_digits[i] = 4'(add_acc - 5'd10);
				carry = 1'b1;
			end else begin
				sum_digits[i] = add_acc[3:0];
				carry = 1'b0;
			end
			// decimal subtract, top bit set means the digit went negative
			sub_acc = {1'b0, bus.digits[i]} - {1'b0, operand} - {4'd0, borrow};
			if (sub_acc[4]) begin
				diff_digits[i] = 4'(sub_acc + 5'd10);
				borrow = 1'b1;
			end else begin
				diff_digits[i] = sub_acc[3:0];
				borrow = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.digits <= '0;
		end else if (delta_valid) begin
			if (delta[ddr_pkg::DELTA_WIDTH-1]) begin
				// floor at zero
				bus.digits <= borrow ? '0 : diff_digits;
			end else begin
				// saturate at 999999
				bus.digits <= carry ? {ddr_pkg::NUM_DIGITS{4'd9}} : sum_digits;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/matrix_scan.sv */
/* matrix scanner
   one row per clock, red columns on the hit row and green elsewhere */
`timescale 1ns/1ns
`default_nettype none

module matrix_scan (
	input wire logic clk,
	input wire logic reset,
	game_if.output_side bus,
	output logic [ddr_pkg::NUM_ROWS-1:0] row,
	output logic [ddr_pkg::NUM_LANES-1:0] green,
	output logic [ddr_pkg::NUM_LANES-1:0] red
);

	logic [ddr_pkg::ROW_BITS-1:0] scan;
	logic hit_row;

	assign hit_row = (scan == ddr_pkg::ROW_BITS'(ddr_pkg::HIT_ROW));

	always_ff @(posedge clk) begin
		if (reset) begin
			scan <= '0;
			row <= '0;
			green <= '0;
			red <= '0;
		end else begin
			scan <= scan + 1'b1;
			row <= ddr_pkg::NUM_ROWS'(1) << scan;
			// colour split by row
			red <= hit_row ? bus.field[scan] : '0;
			green <= hit_row ? '0 : bus.field[scan];
		end
	end

endmodule

`default_nettype wire

/* verilog/seg_display.sv */
/* seven-segment encoder
   turns the six BCD score digits into active-low segment patterns */
`timescale 1ns/1ns
`default_nettype none

module seg_display (
	game_if.output_side bus,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	// segment a in bit 0, g in bit 6, low lights the segment
	function automatic logic [6:0] encode(input logic [3:0] bcd);
		case (bcd)
			4'd0: encode = 7'b1000000;
			4'd1: encode = 7'b1111001;
			4'd2: encode = 7'b0100100;
			4'd3: encode = 7'b0110000;
			4'd4: encode = 7'b0011001;
			4'd5: encode = 7'b0010010;
			4'd6: encode = 7'b0000010;
			4'd7: encode = 7'b1111000;
			4'd8: encode = 7'b0000000;
			4'd9: encode = 7'b0010000;
			// not a decimal digit, blank
			default: encode = 7'b1111111;
		endcase
	endfunction

	assign hex0 = encode(bus.digits[0]);
	assign hex1 = encode(bus.digits[1]);
	assign hex2 = encode(bus.digits[2]);
	assign hex3 = encode(bus.digits[3]);
	assign hex4 = encode(bus.digits[4]);
	assign hex5 = encode(bus.digits[5]);

endmodule

`default_nettype wire

/* verilog/ddr_game.sv */
/* falling-note rhythm game top
   keys and notes in, LED matrix scan and BCD score out */
`timescale 1ns/1ns
`default_nettype none

module ddr_game (
	input wire logic clk,
	input wire logic reset,
	input wire logic [ddr_pkg::NUM_LANES-1:0] key,
	output logic [ddr_pkg::NUM_ROWS-1:0] row,
	output logic [ddr_pkg::NUM_LANES-1:0] green,
	output logic [ddr_pkg::NUM_LANES-1:0] red,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	game_if bus ();

	logic signed [ddr_pkg::DELTA_WIDTH-1:0] delta;
	logic delta_valid;

	// input side
	key_sampler u_keys (.clk(clk), .reset(reset), .key(key), .bus(bus.input_side));
	note_source u_source (.clk(clk), .reset(reset), .bus(bus.input_side));

	// processing
	note_lanes u_lanes (
		.clk(clk), .reset(reset), .bus(bus.process_side),
		.delta(delta), .delta_valid(delta_valid)
	);
	score_keeper u_score (
		.clk(clk), .reset(reset), .delta(delta),
		.delta_valid(delta_valid), .bus(bus.process_side)
	);

	// output side
	matrix_scan u_scan (
		.clk(clk), .reset(reset), .bus(bus.output_side),
		.row(row), .green(green), .red(red)
	);
	seg_display u_seg (
		.bus(bus.output_side), .hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

endmodule

`default_nettype wire

/* testbench/ddr_game_tb.sv */
/* rhythm game testbench
   random key presses checked against a cycle model of notes, scan and score */
`timescale 1ns/1ns
`default_nettype none

module ddr_game_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = 400 * ddr_pkg::BEAT_CYCLES + 200;
	localparam int FLOOR_PRESSES = 8;
	localparam int HOLD_CYCLES = 30;
	localparam int RANDOM_PRESSES = 600;

	logic clk;
	logic reset;
	logic [ddr_pkg::NUM_LANES-1:0] key;
	logic [ddr_pkg::NUM_ROWS-1:0] row;
	logic [ddr_pkg::NUM_LANES-1:0] green;
	logic [ddr_pkg::NUM_LANES-1:0] red;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;

	// model state, one update per rising edge
	logic [ddr_pkg::NUM_LANES-1:0] key_seen1;
	logic [ddr_pkg::NUM_LANES-1:0] key_seen2;
	logic [ddr_pkg::NUM_LANES-1:0] key_seen3;
	logic [ddr_pkg::NUM_LANES-1:0] m_press;
	logic [ddr_pkg::LFSR_WIDTH-1:0] m_lfsr;
	logic [ddr_pkg::NUM_ROWS-1:0][ddr_pkg::NUM_LANES-1:0] m_field;
	logic [ddr_pkg::NUM_ROWS-1:0] m_row;
	logic [ddr_pkg::NUM_LANES-1:0] m_green;
	logic [ddr_pkg::NUM_LANES-1:0] m_red;
	logic m_beat;
	logic m_delta_valid;
	int m_edges;
	int m_delta;
	int m_score;
	int m_scan;

	logic [15:0] rng;
	int cycle_count = 0;
	int err_rows = 0;
	int err_score = 0;
	int err_onehot = 0;

	ddr_game uut (
		.clk(clk), .reset(reset), .key(key), .row(row), .green(green), .red(red),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// stimulus generator, taps 16 14 13 11
	function automatic logic [15:0] rng_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int take_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			rng = rng_step(rng);
			value = (value << 1) | int'(rng[0]);
		end
		return value;
	endfunction

	// note generator, taps 9 and 5, new bit enters at bit 0
	function automatic logic [ddr_pkg::LFSR_WIDTH-1:0] note_step(
		input logic [ddr_pkg::LFSR_WIDTH-1:0] s
	);
		return {s[ddr_pkg::LFSR_WIDTH-2:0], s[8] ^ s[4]};
	endfunction

	// active-low segments, a in bit 0
	function automatic logic [6:0] seg_pattern(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic logic [3:0] hex_digit(input logic [6:0] seg);
		logic [3:0] digit;
		digit = 4'hf;
		for (int d = 0; d < 10; d++) begin
			if (seg_pattern(d) == seg) digit = 4'(d);
		end
		return digit;
	endfunction

	function automatic logic [ddr_pkg::NUM_DIGITS-1:0][3:0] to_bcd(input int value);
		logic [ddr_pkg::NUM_DIGITS-1:0][3:0] bcd;
		int v;
		v = value;
		for (int i = 0; i < ddr_pkg::NUM_DIGITS; i++) begin
			bcd[i] = 4'(v % 10);
			v = v / 10;
		end
		return bcd;
	endfunction

	task automatic model_edge();
		logic [ddr_pkg::NUM_ROWS-1:0][ddr_pkg::NUM_LANES-1:0] work;
		int sum;
		if (reset) begin
			key_seen1 = '0;
			key_seen2 = '0;
			key_seen3 = '0;
			m_press = '0;
			m_lfsr = ddr_pkg::LFSR_SEED;
			m_field = '0;
			m_row = '0;
			m_green = '0;
			m_red = '0;
			m_beat = 1'b0;
			m_delta_valid = 1'b0;
			m_edges = 0;
			m_delta = 0;
			m_score = 0;
			m_scan = 0;
		end else begin
			// last delta lands on the score, clamped both ways
			if (m_delta_valid) begin
				m_score = m_score + m_delta;
				if (m_score < 0) m_score = 0;
				if (m_score > 999999) m_score = 999999;
			end
			// scan shows the field as it was before this edge
			m_row = '0;
			m_row[m_scan] = 1'b1;
			m_red = (m_scan == ddr_pkg::HIT_ROW) ? m_field[m_scan] : '0;
			m_green = (m_scan == ddr_pkg::HIT_ROW) ? '0 : m_field[m_scan];
			m_scan = (m_scan + 1) % ddr_pkg::NUM_ROWS;
			// judge, then shift on beat
			work = m_field;
			sum = 0;
			for (int l = 0; l < ddr_pkg::NUM_LANES; l++) begin
				if (m_press[l]) begin
					if (work[ddr_pkg::HIT_ROW][l]) begin
						sum = sum + int'(ddr_pkg::PTS_HIT);
						work[ddr_pkg::HIT_ROW][l] = 1'b0;
					end else if (work[ddr_pkg::NEAR_ROW][l]) begin
						sum = sum + int'(ddr_pkg::PTS_NEAR);
						work[ddr_pkg::NEAR_ROW][l] = 1'b0;
					end else begin
						sum = sum - int'(ddr_pkg::PTS_MISS);
					end
				end
			end
			if (m_beat) begin
				for (int r = 0; r < ddr_pkg::NUM_ROWS - 1; r++) work[r] = work[r+1];
				work[ddr_pkg::NUM_ROWS-1] = m_lfsr[ddr_pkg::NUM_LANES-1:0];
			end
			m_field = work;
			m_delta = sum;
			m_delta_valid = |m_press;
			// three key samples before a press
			m_press = key_seen2 & ~key_seen3;
			key_seen3 = key_seen2;
			key_seen2 = key_seen1;
			key_seen1 = key;
			m_edges = m_edges + 1;
			m_beat = (m_edges % ddr_pkg::BEAT_CYCLES) == 0;
			if (m_beat) m_lfsr = note_step(m_lfsr);
		end
	endtask

	task automatic check_rows(
		input string name,
		input logic [ddr_pkg::NUM_ROWS-1:0] exp_row,
		input logic [ddr_pkg::NUM_LANES-1:0] exp_green,
		input logic [ddr_pkg::NUM_LANES-1:0] exp_red
	);
		if (row !== exp_row || green !== exp_green || red !== exp_red) begin
			err_rows++;
			$display("FAILED %s at cycle %0d: expected row %b green %b red %b,",
				name, cycle_count, exp_row, exp_green, exp_red);
			$display("  actual row %b green %b red %b", row, green, red);
		end
	endtask

	task automatic check_score(
		input string name,
		input logic [ddr_pkg::NUM_DIGITS-1:0][3:0] expected
	);
		logic [ddr_pkg::NUM_DIGITS-1:0][3:0] actual;
		actual[0] = hex_digit(hex0);
		actual[1] = hex_digit(hex1);
		actual[2] = hex_digit(hex2);
		actual[3] = hex_digit(hex3);
		actual[4] = hex_digit(hex4);
		actual[5] = hex_digit(hex5);
		if (actual !== expected) begin
			err_score++;
			$display("FAILED %s at cycle %0d: expected %h, actual %h",
				name, cycle_count, expected, actual);
		end
	endtask

	task automatic check_onehot(input logic [ddr_pkg::NUM_ROWS-1:0] value);
		if (!$onehot(value)) begin
			err_onehot++;
			$display("row output %b at cycle %0d does not select exactly one row",
				value, cycle_count);
		end
	endtask

	// key held for hold cycles, then idle for gap cycles
	task automatic press_keys(input logic [ddr_pkg::NUM_LANES-1:0] pattern,
		input int hold, input int gap);
		@(posedge clk);
		key <= pattern;
		repeat (hold) @(posedge clk);
		key <= '0;
		repeat (gap - 1) @(posedge clk);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		model_edge();
	end

	always @(negedge clk) begin
		if (cycle_count > 0) begin
			check_rows("scan", m_row, m_green, m_red);
			check_score("score", to_bcd(m_score));
			// scan starts at the first edge that sees reset low
			if (m_edges > 0) check_onehot(row);
		end
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin
		int pattern;
		key = '0;
		reset = 1'b1;
		rng = 16'd12;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_rows("reset", '0, '0, '0);
		check_score("reset", to_bcd(0));
		@(posedge clk);
		reset <= 1'b0;

		// misses before any note reaches the hit zone
		for (int i = 0; i < FLOOR_PRESSES; i++) begin
			pattern = take_bits(4);
			if (pattern == 0) pattern = 15;
			press_keys(4'(pattern), 1, 2 + take_bits(3));
		end
		repeat (6) @(posedge clk);
		@(negedge clk);
		check_score("floor", to_bcd(0));

		// hold the lanes of fresh hit row notes, a repeat press would miss
		do begin
			@(negedge clk);
		end while (m_field[ddr_pkg::HIT_ROW] == '0 || (m_edges % ddr_pkg::BEAT_CYCLES) != 1);
		press_keys(m_field[ddr_pkg::HIT_ROW], HOLD_CYCLES, 4);

		for (int i = 0; i < RANDOM_PRESSES; i++) begin
			pattern = take_bits(4);
			press_keys(4'(pattern), 1, 2 + take_bits(3));
		end
		repeat (8) @(posedge clk);
		@(negedge clk);

		$display("errors: rows %0d, score %0d, onehot %0d", err_rows, err_score, err_onehot);
		if (err_rows + err_score + err_onehot == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* ddr_game.f */
verilog/ddr_pkg.sv
verilog/game_if.sv
verilog/key_sampler.sv
verilog/note_source.sv
verilog/note_lanes.sv
verilog/score_keeper.sv
verilog/matrix_scan.sv
verilog/seg_display.sv
verilog/ddr_game.sv
testbench/ddr_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ddr_game testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f ddr_game.f \
	--top-module ddr_game_tb -o ddr_game_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/ddr_game_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
